// ==== sim.f ====
+incdir+.
dac_data_pkg.sv
dac_ctrl_pkg.sv
dac_ctrl_regs.sv
supply_monitor.sv
resync_pipe.sv
dac_resync_top.sv
dac_resync_checker.sv
tb_dac_resync.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dac_resync
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

FAIL_MSG  := CHECKS FAILED
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_dac_resync.sv ====
`timescale 1ns/1ns

module tb_dac_resync;

    import dac_data_pkg::*;
    import dac_ctrl_pkg::*;

    localparam int NROWS     = 12;
    localparam int LIMIT     = NROWS * 20 + 200;    // Watchdog budget in cycles
    localparam int RDY_STALL = 0;
    localparam int RDY_HIGH  = 1;
    localparam int RDY_LOW   = 2;
    localparam mon_code_t VDD_NOM  = 8'd200;
    localparam mon_code_t VSS_NOM  = 8'd5;
    localparam mon_code_t IREF_NOM = 8'd100;

    typedef struct packed {
        therm_word_t therm;
        therm_word_t therm_b;
        bin_word_t   bin;
        bin_word_t   bin_b;
        logic        pair_err;
        logic        therm_err;
    } row_t;

    // therm, therm_b, bin, bin_b, expected pair_err, expected therm_err
    row_t rows [NROWS] = '{
        '{17'h00000, 17'h1FFFF, 7'h00, 7'h7F, 1'b0, 1'b0},
        '{17'h00001, 17'h1FFFE, 7'h15, 7'h6A, 1'b0, 1'b0},
        '{17'h000FF, 17'h1FF00, 7'h7F, 7'h00, 1'b0, 1'b0},
        '{17'h1FFFF, 17'h00000, 7'h01, 7'h7E, 1'b0, 1'b0},
        '{17'h00005, 17'h1FFFA, 7'h2A, 7'h55, 1'b0, 1'b1},   // Gap in the run
        '{17'h00F00, 17'h1F0FF, 7'h40, 7'h3F, 1'b0, 1'b1},   // Run not at bit 0
        '{17'h0000F, 17'h1FFF0, 7'h33, 7'h4D, 1'b1, 1'b0},   // Redundant cell pair broken
        '{17'h0003F, 17'h0FFC0, 7'h10, 7'h6F, 1'b1, 1'b0},   // Top cell pair broken
        '{17'h00006, 17'h1FFF9, 7'h05, 7'h7F, 1'b1, 1'b1},
        '{17'h0FFFF, 17'h10000, 7'h7E, 7'h01, 1'b0, 1'b0},
        '{17'h10000, 17'h0FFFF, 7'h00, 7'h7F, 1'b0, 1'b1},
        '{17'h00003, 17'h1FFFC, 7'h55, 7'h2A, 1'b0, 1'b0}
    };

    logic        clkin_binary_0;
    logic        clkinb_binary_0;
    logic        cfg_wr;
    reg_addr_e   cfg_addr;
    logic [1:0]  cfg_wdata;
    mon_code_t   vdd_code;
    mon_code_t   vss_code;
    mon_code_t   iref_code;
    logic        in_valid;
    therm_word_t in_therm;
    therm_word_t in_therm_b;
    bin_word_t   in_bin;
    bin_word_t   in_bin_b;
    logic        out_ready;
    logic        in_ready;
    logic        out_valid;
    therm_word_t out_therm;
    therm_word_t out_therm_b;
    bin_word_t   out_bin;
    bin_word_t   out_bin_b;
    logic        pair_err;
    logic        therm_err;
    mon_code_t   atb1;
    mon_code_t   atb0;
    logic        atb_en;

    int   seed = 32'h73cf6e3b;
    int   ready_mode;
    bit   lat_check;          // Fixed two-cycle latency expected
    int   cur_row;
    int   cyc;
    int   idx;
    int   exp_idx[$];         // Rows accepted and not yet seen at the output
    int   exp_cyc[$];
    mon_code_t exp_atb1;
    mon_code_t exp_atb0;

    dac_resync_top dac_resync_top_i (.*);

    always #10 clkin_binary_0 = ~clkin_binary_0;

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t ns %s: got %0h, expected %0h", $time, what, got, exp);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    task automatic write_reg(input reg_addr_e addr, input logic [1:0] data);
        cfg_wr    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(posedge clkin_binary_0);
        #2;
        cfg_wr    = 1'b0;
    endtask

    task automatic present_row(input int r);
        cur_row    = r;
        in_therm   = rows[r].therm;
        in_therm_b = rows[r].therm_b;
        in_bin     = rows[r].bin;
        in_bin_b   = rows[r].bin_b;
    endtask

    // Holds the row on the input until the bank takes it
    task automatic send_row(input int r);
        bit taken;
        taken = 1'b0;
        present_row(r);
        in_valid = 1'b1;
        while (!taken) begin
            @(negedge clkin_binary_0);
            taken = in_ready;
            @(posedge clkin_binary_0);
            #2;
        end
        in_valid = 1'b0;
    endtask

    task automatic set_ready_mode(input int m);
        @(negedge clkin_binary_0);
        ready_mode = m;
        @(posedge clkin_binary_0);
        #2;
    endtask

    task automatic drain();
        while (exp_idx.size() != 0) begin
            @(posedge clkin_binary_0);
            #2;
        end
    endtask

    task automatic supply_fault_test(input mon_code_t vdd, input mon_code_t vss,
                                     input mon_code_t iref);
        vdd_code  = vdd;
        vss_code  = vss;
        iref_code = iref;
        @(posedge clkin_binary_0);
        #2;
        check(in_ready, 0, "in_ready one cycle after a code left its window");
        present_row(0);
        in_valid = 1'b1;
        repeat (4) begin
            @(posedge clkin_binary_0);
            #2;
            check(in_ready, 0, "in_ready during supply fault");
        end
        in_valid = 1'b0;
        check(exp_idx.size(), 0, "samples accepted during supply fault");
        vdd_code  = VDD_NOM;
        vss_code  = VSS_NOM;
        iref_code = IREF_NOM;
        send_row(1);                                 // Traffic resumes
        drain();
    endtask

    always @(posedge clkin_binary_0) begin
        #2;
        if (ready_mode == RDY_STALL) begin
            out_ready = ($random(seed) & 3) != 0;
        end else begin
            out_ready = (ready_mode == RDY_HIGH);
        end
    end

    // Reference model, transfers are seen half a cycle before their edge
    always @(negedge clkin_binary_0) begin
        cyc++;
        if (in_valid && in_ready) begin
            exp_idx.push_back(cur_row);
            exp_cyc.push_back(cyc);
        end
        if (out_valid && out_ready) begin
            check(exp_idx.size() != 0, 1, "output transfer with no sample in flight");
            idx = exp_idx.pop_front();
            if (lat_check) check(cyc - exp_cyc[0], 2, "latency from acceptance");
            void'(exp_cyc.pop_front());
            check(out_therm, rows[idx].therm, "out_therm");
            check(out_therm_b, rows[idx].therm_b, "out_therm_b");
            check(out_bin, rows[idx].bin, "out_bin");
            check(out_bin_b, rows[idx].bin_b, "out_bin_b");
            check(pair_err, rows[idx].pair_err, "pair_err");
            check(therm_err, rows[idx].therm_err, "therm_err");
        end
    end

    initial begin
        repeat (LIMIT) @(posedge clkin_binary_0);
        $display("Timeout: the test did not finish within %0d clock cycles", LIMIT);
        $display("CHECKS FAILED");
        $fatal(1);
    end

    initial begin
        clkin_binary_0  = 1'b0;
        clkinb_binary_0 = 1'b0;
        cfg_wr = 1'b0;
        cfg_addr = REG_CTRL;
        cfg_wdata = 2'b00;
        vdd_code = VDD_NOM;
        vss_code = VSS_NOM;
        iref_code = IREF_NOM;
        in_valid = 1'b0;
        present_row(0);
        out_ready = 1'b1;
        ready_mode = RDY_HIGH;
        lat_check = 1'b0;
        cyc = 0;
        repeat (16) @(posedge clkin_binary_0);
        #2;
        clkinb_binary_0 = 1'b1;
        @(posedge clkin_binary_0);
        #2;
        check(in_ready, 0, "in_ready while powered down");
        check(out_valid, 0, "out_valid after reset");
        check(atb_en, 0, "atb_en after reset");
        write_reg(REG_CTRL, 2'b01);
        check(in_ready, 1, "in_ready after power enable");

        set_ready_mode(RDY_STALL);                   // Rows under random back-pressure
        for (int i = 0; i < NROWS; i++) send_row(i);
        drain();
        set_ready_mode(RDY_HIGH);
        lat_check = 1'b1;
        for (int i = 0; i < NROWS; i++) send_row(i);
        drain();
        lat_check = 1'b0;

        supply_fault_test(8'd230, VSS_NOM, IREF_NOM);
        supply_fault_test(VDD_NOM, 8'd20, IREF_NOM);
        supply_fault_test(VDD_NOM, VSS_NOM, 8'd60);

        for (int s = 0; s < 4; s++) begin
            write_reg(REG_ATB, 2'(s));
            @(posedge clkin_binary_0);
            #2;
            exp_atb1 = (s == 3) ? IREF_NOM : ((s == 0) ? 8'd0 : VDD_NOM);
            exp_atb0 = (s == 3) ? IREF_NOM : ((s == 0) ? 8'd0 : VSS_NOM);
            check(atb_en, s != 0, "atb_en for test-bus select");
            check(atb1, exp_atb1, "atb1 for test-bus select");
            check(atb0, exp_atb0, "atb0 for test-bus select");
        end

        set_ready_mode(RDY_LOW);                     // Fill both stages
        send_row(2);
        send_row(4);
        check(out_valid, 1, "out_valid with both stages full");
        check(in_ready, 0, "in_ready with both stages full");
        write_reg(REG_CTRL, 2'b00);
        @(posedge clkin_binary_0);
        #2;
        check(out_valid, 0, "out_valid after power-down");
        check(out_therm, 0, "out_therm after power-down");
        check(out_therm_b, 0, "out_therm_b after power-down");
        check(out_bin, 0, "out_bin after power-down");
        check(in_ready, 0, "in_ready after power-down");
        check(atb_en, 0, "atb_en after power-down");
        check(atb1, 0, "atb1 after power-down");
        exp_idx.delete();                            // In-flight rows are lost
        exp_cyc.delete();
        write_reg(REG_CTRL, 2'b01);
        set_ready_mode(RDY_HIGH);
        for (int i = 0; i < 4; i++) send_row(i);
        drain();

        if (dac_resync_top_i.dac_resync_checker_i.assert_fails == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== dac_resync_checker.sv ====
`timescale 1ns/1ns

module dac_resync_checker (
    input logic                       clkin_binary_0,
    input logic                       clkinb_binary_0,
    input logic                       power_en,
    input logic                       supply_ok,
    input logic                       in_ready,
    input logic                       out_valid,
    input logic                       out_ready,
    input dac_data_pkg::therm_word_t  out_therm,
    input dac_data_pkg::therm_word_t  out_therm_b,
    input dac_data_pkg::bin_word_t    out_bin,
    input dac_data_pkg::bin_word_t    out_bin_b,
    input logic                       pair_err,
    input logic                       therm_err
);

    int assert_fails = 0;   // Count of failed assertions

    // Output stage is flushed once the bank powers down
    pwr_down_empty: assert property (@(posedge clkin_binary_0) disable iff (!clkinb_binary_0)
        !power_en |=> !out_valid)
        else begin
            $error("out_valid high while the bank is powered down");
            assert_fails++;
        end

    stall_hold: assert property (@(posedge clkin_binary_0) disable iff (!clkinb_binary_0)
        out_valid && !out_ready && power_en |=> out_valid && $stable(out_therm)
            && $stable(out_therm_b) && $stable(out_bin) && $stable(out_bin_b)
            && $stable(pair_err) && $stable(therm_err))
        else begin
            $error("Output fields changed while stalled");
            assert_fails++;
        end

    no_accept_on_fault: assert property (@(posedge clkin_binary_0) disable iff (!clkinb_binary_0)
        !supply_ok |-> !in_ready)
        else begin
            $error("in_ready high with supply out of window");
            assert_fails++;
        end

endmodule

bind dac_resync_top dac_resync_checker dac_resync_checker_i (
    .clkin_binary_0  (clkin_binary_0),
    .clkinb_binary_0 (clkinb_binary_0),
    .power_en        (power_en),
    .supply_ok       (supply_ok),
    .in_ready        (in_ready),
    .out_valid       (out_valid),
    .out_ready       (out_ready),
    .out_therm       (out_therm),
    .out_therm_b     (out_therm_b),
    .out_bin         (out_bin),
    .out_bin_b       (out_bin_b),
    .pair_err        (pair_err),
    .therm_err       (therm_err)
);

// ==== dac_resync_top.sv ====
`timescale 1ns/1ns

module dac_resync_top (
    input  logic                              clkin_binary_0,
    input  logic                              clkinb_binary_0,
    input  logic                              cfg_wr,
    input  dac_ctrl_pkg::reg_addr_e           cfg_addr,
    input  logic [dac_ctrl_pkg::CFG_DW-1:0]   cfg_wdata,
    input  dac_data_pkg::mon_code_t           vdd_code,
    input  dac_data_pkg::mon_code_t           vss_code,
    input  dac_data_pkg::mon_code_t           iref_code,
    input  logic                              in_valid,
    input  dac_data_pkg::therm_word_t         in_therm,
    input  dac_data_pkg::therm_word_t         in_therm_b,
    input  dac_data_pkg::bin_word_t           in_bin,
    input  dac_data_pkg::bin_word_t           in_bin_b,
    input  logic                              out_ready,
    output logic                              in_ready,
    output logic                              out_valid,
    output dac_data_pkg::therm_word_t         out_therm,
    output dac_data_pkg::therm_word_t         out_therm_b,
    output dac_data_pkg::bin_word_t           out_bin,
    output dac_data_pkg::bin_word_t           out_bin_b,
    output logic                              pair_err,
    output logic                              therm_err,
    output dac_data_pkg::mon_code_t           atb1,
    output dac_data_pkg::mon_code_t           atb0,
    output logic                              atb_en
);

    import dac_data_pkg::*;

    logic     power_en;    // Bank enable from the control register
    atb_sel_e atb_sel;
    logic     supply_ok;   // All monitor codes inside their windows

    dac_ctrl_regs dac_ctrl_regs_i (
        .clkin_binary_0  (clkin_binary_0),
        .clkinb_binary_0 (clkinb_binary_0),
        .cfg_wr          (cfg_wr),
        .cfg_addr        (cfg_addr),
        .cfg_wdata       (cfg_wdata),
        .power_en        (power_en),
        .atb_sel         (atb_sel)
    );

    supply_monitor supply_monitor_i (
        .clkin_binary_0  (clkin_binary_0),
        .clkinb_binary_0 (clkinb_binary_0),
        .vdd_code        (vdd_code),
        .vss_code        (vss_code),
        .iref_code       (iref_code),
        .power_en        (power_en),
        .atb_sel         (atb_sel),
        .supply_ok       (supply_ok),
        .atb1            (atb1),
        .atb0            (atb0),
        .atb_en          (atb_en)
    );

    resync_pipe resync_pipe_i (
        .clkin_binary_0  (clkin_binary_0),
        .clkinb_binary_0 (clkinb_binary_0),
        .power_en        (power_en),
        .supply_ok       (supply_ok),
        .in_valid        (in_valid),
        .in_therm        (in_therm),
        .in_therm_b      (in_therm_b),
        .in_bin          (in_bin),
        .in_bin_b        (in_bin_b),
        .out_ready       (out_ready),
        .in_ready        (in_ready),
        .out_valid       (out_valid),
        .out_therm       (out_therm),
        .out_therm_b     (out_therm_b),
        .out_bin         (out_bin),
        .out_bin_b       (out_bin_b),
        .pair_err        (pair_err),
        .therm_err       (therm_err)
    );

endmodule

// ==== resync_pipe.sv ====
`timescale 1ns/1ns

module resync_pipe (
    input  logic                       clkin_binary_0,
    input  logic                       clkinb_binary_0,
    input  logic                       power_en,
    input  logic                       supply_ok,
    input  logic                       in_valid,
    input  dac_data_pkg::therm_word_t  in_therm,
    input  dac_data_pkg::therm_word_t  in_therm_b,
    input  dac_data_pkg::bin_word_t    in_bin,
    input  dac_data_pkg::bin_word_t    in_bin_b,
    input  logic                       out_ready,
    output logic                       in_ready,
    output logic                       out_valid,
    output dac_data_pkg::therm_word_t  out_therm,
    output dac_data_pkg::therm_word_t  out_therm_b,
    output dac_data_pkg::bin_word_t    out_bin,
    output dac_data_pkg::bin_word_t    out_bin_b,
    output logic                       pair_err,
    output logic                       therm_err
);

    import dac_data_pkg::*;

    // Stage 1 registers
    logic        s1_valid;
    therm_word_t s1_therm;
    therm_word_t s1_therm_b;
    bin_word_t   s1_bin;
    bin_word_t   s1_bin_b;
    logic        s1_pair_err;

    // Handshake and checks
    logic        s1_ready;
    logic        s2_ready;
    logic        s1_load;
    logic        s2_load;
    logic        pair_bad;
    therm_word_t therm_inc;
    logic        therm_bad;

    assign s2_ready = !out_valid || out_ready;        // Output slot free or draining
    assign s1_ready = !s1_valid || s2_ready;
    assign in_ready = power_en && supply_ok && s1_ready;

    assign s1_load = in_valid && in_ready;
    assign s2_load = s1_valid && s2_ready;

    // A cell whose data equals its complement is a broken pair
    assign pair_bad = (|(in_therm ~^ in_therm_b)) || (|(in_bin ~^ in_bin_b));

    // Ones from bit 0 upwards turn into a single carry bit on increment
    assign therm_inc = s1_therm + therm_word_t'(1);
    assign therm_bad = |(therm_inc & s1_therm);

    // Stage 1, captures the sample and its pairing status
    always_ff @(posedge clkin_binary_0 or negedge clkinb_binary_0) begin
        if (!clkinb_binary_0) begin
            s1_valid    <= 1'b0;
            s1_therm    <= '0;
            s1_therm_b  <= '0;
            s1_bin      <= '0;
            s1_bin_b    <= '0;
            s1_pair_err <= 1'b0;
        end else if (!power_en) begin       // Power-down flushes the stage
            s1_valid    <= 1'b0;
            s1_therm    <= '0;
            s1_therm_b  <= '0;
            s1_bin      <= '0;
            s1_bin_b    <= '0;
            s1_pair_err <= 1'b0;
        end else if (s1_load) begin
            s1_valid    <= 1'b1;
            s1_therm    <= in_therm;
            s1_therm_b  <= in_therm_b;
            s1_bin      <= in_bin;           // Redundant bit 0 rides along
            s1_bin_b    <= in_bin_b;
            s1_pair_err <= pair_bad;
        end else if (s2_load) begin
            s1_valid    <= 1'b0;
        end
    end

    // Stage 2, drives the switch outputs
    always_ff @(posedge clkin_binary_0 or negedge clkinb_binary_0) begin
        if (!clkinb_binary_0) begin
            out_valid   <= 1'b0;
            out_therm   <= '0;
            out_therm_b <= '0;
            out_bin     <= '0;
            out_bin_b   <= '0;
            pair_err    <= 1'b0;
            therm_err   <= 1'b0;
        end else if (!power_en) begin       // Outputs held cleared while powered down
            out_valid   <= 1'b0;
            out_therm   <= '0;
            out_therm_b <= '0;
            out_bin     <= '0;
            out_bin_b   <= '0;
            pair_err    <= 1'b0;
            therm_err   <= 1'b0;
        end else if (s2_load) begin
            out_valid   <= 1'b1;
            out_therm   <= s1_therm;
            out_therm_b <= s1_therm_b;
            out_bin     <= s1_bin;
            out_bin_b   <= s1_bin_b;
            pair_err    <= s1_pair_err;
            therm_err   <= therm_bad;
        end else if (out_ready) begin
            out_valid   <= 1'b0;             // Taken, nothing behind it
        end
    end

endmodule

// ==== supply_monitor.sv ====
`timescale 1ns/1ns

`include "dac_resync_cfg.svh"

module supply_monitor (
    input  logic                     clkin_binary_0,
    input  logic                     clkinb_binary_0,
    input  dac_data_pkg::mon_code_t  vdd_code,
    input  dac_data_pkg::mon_code_t  vss_code,
    input  dac_data_pkg::mon_code_t  iref_code,
    input  logic                     power_en,
    input  dac_data_pkg::atb_sel_e   atb_sel,
    output logic                     supply_ok,
    output dac_data_pkg::mon_code_t  atb1,
    output dac_data_pkg::mon_code_t  atb0,
    output logic                     atb_en
);

    import dac_data_pkg::*;

    logic      vdd_ok;
    logic      vss_ok;
    logic      iref_ok;
    mon_code_t atb1_nxt;
    mon_code_t atb0_nxt;
    logic      atb_en_nxt;

    // Window checks on the monitor codes
    assign vdd_ok  = (vdd_code >= `VDD_MIN) && (vdd_code <= `VDD_MAX);
    assign vss_ok  = (vss_code <= `VSS_MAX);                              // Ground has no lower bound
    assign iref_ok = (iref_code >= `IREF_MIN) && (iref_code <= `IREF_MAX);

    // Test-bus line selection
    always_comb begin
        atb1_nxt   = '0;
        atb0_nxt   = '0;
        atb_en_nxt = 1'b0;
        if (power_en) begin                      // Powered-down bank keeps the bus quiet
            unique case (atb_sel)
                ATB_OFF: begin
                    atb_en_nxt = 1'b0;
                end
                ATB_SUPPLY, ATB_SUPPLY_ALT: begin
                    atb1_nxt   = vdd_code;
                    atb0_nxt   = vss_code;
                    atb_en_nxt = 1'b1;
                end
                ATB_IREF: begin
                    atb1_nxt   = iref_code;      // Same code on both lines
                    atb0_nxt   = iref_code;
                    atb_en_nxt = 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clkin_binary_0 or negedge clkinb_binary_0) begin
        if (!clkinb_binary_0) begin
            supply_ok <= 1'b0;
            atb1      <= '0;
            atb0      <= '0;
            atb_en    <= 1'b0;
        end else begin
            supply_ok <= vdd_ok && vss_ok && iref_ok;
            atb1      <= atb1_nxt;
            atb0      <= atb0_nxt;
            atb_en    <= atb_en_nxt;
        end
    end

endmodule

// ==== dac_ctrl_regs.sv ====
`timescale 1ns/1ns

module dac_ctrl_regs (
    input  logic                              clkin_binary_0,
    input  logic                              clkinb_binary_0,
    input  logic                              cfg_wr,
    input  dac_ctrl_pkg::reg_addr_e           cfg_addr,
    input  logic [dac_ctrl_pkg::CFG_DW-1:0]   cfg_wdata,
    output logic                              power_en,
    output dac_data_pkg::atb_sel_e            atb_sel
);

    import dac_ctrl_pkg::*;
    import dac_data_pkg::*;

    logic wr_ctrl;
    logic wr_atb;

    // Address decode, anything else is dropped
    assign wr_ctrl = cfg_wr && (cfg_addr == REG_CTRL);
    assign wr_atb  = cfg_wr && (cfg_addr == REG_ATB);

    // Power enable, bank starts powered down
    always_ff @(posedge clkin_binary_0 or negedge clkinb_binary_0) begin
        if (!clkinb_binary_0) begin
            power_en <= 1'b0;
        end else if (wr_ctrl) begin
            power_en <= cfg_wdata[CTRL_PWR_BIT];
        end
    end

    // Test-bus select, bus starts disabled
    always_ff @(posedge clkin_binary_0 or negedge clkinb_binary_0) begin
        if (!clkinb_binary_0) begin
            atb_sel <= ATB_OFF;
        end else if (wr_atb) begin
            atb_sel <= atb_sel_e'(cfg_wdata[ATB_SEL_W-1:0]);   // All four codes are legal
        end
    end

endmodule

// ==== dac_ctrl_pkg.sv ====
`include "dac_resync_cfg.svh"

package dac_ctrl_pkg;

    // Register addresses, other codes are not decoded
    typedef enum logic [`REG_AW-1:0] {
        REG_CTRL = 2'd0,   // Bit 0 power enable
        REG_ATB  = 2'd1    // Bits 1:0 test-bus select
    } reg_addr_e;

    // Field layout of the control registers
    localparam int CFG_DW       = 2;   // Write data width
    localparam int CTRL_PWR_BIT = 0;   // Power enable position in REG_CTRL
    localparam int ATB_SEL_W    = 2;   // Test-bus select width in REG_ATB

endpackage

// ==== dac_data_pkg.sv ====
`include "dac_resync_cfg.svh"

package dac_data_pkg;

    // Segment words, data and complement use the same type
    typedef logic [`THERM_W-1:0] therm_word_t;   // Unary coded MSB cells
    typedef logic [`BIN_W-1:0]   bin_word_t;     // Binary cells incl. redundant bit 0

    // Digitized supply, ground and reference-current level
    typedef logic [`MON_W-1:0]   mon_code_t;

    // Test-bus line selection
    typedef enum logic [1:0] {
        ATB_OFF        = 2'b00,   // Both lines zero, bus disabled
        ATB_SUPPLY     = 2'b01,   // Supply on atb1, ground on atb0
        ATB_SUPPLY_ALT = 2'b10,   // Same pair as ATB_SUPPLY
        ATB_IREF       = 2'b11    // Reference code on both lines
    } atb_sel_e;

endpackage

// ==== dac_resync_cfg.svh ====
`ifndef DAC_RESYNC_CFG_SVH
`define DAC_RESYNC_CFG_SVH

// Segment widths fixed by the DAC architecture
`define THERM_W 17                 // Thermometric MSB segment cells
`define BIN_W   7                  // Binary LSB cells, bit 0 is the redundant cell

// Digitized monitor codes
`define MON_W   8

// Supply window, nominal 200 +/- 5 %
`define VDD_MIN 8'd190
`define VDD_MAX 8'd210

// Ground code must stay near zero
`define VSS_MAX 8'd10

// Reference current window, nominal 100 +/- 10 %
`define IREF_MIN 8'd90
`define IREF_MAX 8'd110

// Control register map
`define REG_AW  2

`endif
